// ==== src/tx_dma_pkg.sv ====
// sizes assume a 512-qword buffer, four outstanding tags and 128 qwords per request at most
package tx_dma_pkg;

    //////////////////////////////////////////////////
    // transmit buffer and pointers
    //////////////////////////////////////////////////
    localparam int BUF_ADDR_W = 9;            // qword address into the buffer
    localparam int PTR_W      = 10;           // buffer address plus wrap bit
    localparam int BUF_QWORDS = 512;

    //////////////////////////////////////////////////
    // requests and tags
    //////////////////////////////////////////////////
    localparam int TAG_W    = 2;
    localparam int NUM_TAGS = 4;              // max requests in flight

    localparam int QWORD_W     = 64;
    localparam int CHUNK_W     = 9;           // request size in qwords
    localparam int PAGE_QW_W   = 32;          // page length in qwords
    localparam int HOST_ADDR_W = 64;

    // request size per encoded max read request size (128, 256, 512, 1024 bytes)
    // callers clamp encodings of 3 and above to the last entry
    localparam logic [CHUNK_W-1:0] chunk_qwords [0:3] = '{
        9'd16,
        9'd32,
        9'd64,
        9'd128
    };

endpackage

// ==== src/tlp_pkg.sv ====
// field positions follow the 64-bit trn layout, dword 0 in the upper half of beat 0
package tlp_pkg;

    //////////////////////////////////////////////////
    // header codes
    //////////////////////////////////////////////////
    localparam logic [6:0] CPL_D_FMT_TYPE = 7'b10_01010;  // fmt 3dw with data, type cpl
    localparam logic [2:0] CPL_SC         = 3'b000;       // successful completion

    //////////////////////////////////////////////////
    // beat 0 fields
    //////////////////////////////////////////////////
    // dword 0 sits in bits 63:32
    localparam int FMT_TYPE_LSB = 56;         // fmt/type in 62:56
    localparam int LEN_LSB      = 32;         // length in dwords in 41:32

    // dword 1 sits in bits 31:0
    localparam int STATUS_LSB   = 13;         // completion status in 15:13

    //////////////////////////////////////////////////
    // beat 1 fields
    //////////////////////////////////////////////////
    // dword 2 holds requester id and tag, dword 3 is the first data dword
    localparam int TAG_LSB      = 40;         // tag byte in 47:40

endpackage

// ==== src/completion_parser.sv ====
// completions must be 3dw CplD with an even dword count; no back-pressure on the buffer port
`timescale 1ns/1ps

module completion_parser
    import tx_dma_pkg::*;
    import tlp_pkg::*;
(
    input  logic                  trn_clk,
    input  logic                  reset,

    input  logic [QWORD_W-1:0]    trn_rd,
    input  logic                  trn_rsof_n,
    input  logic                  trn_reof_n,
    input  logic                  trn_rsrc_rdy_n,
    input  logic                  trn_rdst_rdy_n,

    output logic [TAG_W-1:0]      lookup_tag,
    input  logic [PTR_W-1:0]      lookup_addr,

    output logic                  wr_en,
    output logic [BUF_ADDR_W-1:0] wr_addr,
    output logic [QWORD_W-1:0]    wr_data,

    output logic [TAG_W-1:0]      cpl_tag,
    output logic                  cpl_qword
);

    typedef enum logic [1:0] {
        ST_HDR,
        ST_TAG,
        ST_DATA
    } state_t;

    state_t                state;
    logic                  beat;
    logic                  hdr_ok;
    logic                  take_tag;
    logic                  take_data;
    logic                  write_qw;
    logic [CHUNK_W-1:0]    qw_left;
    logic [BUF_ADDR_W-1:0] wr_ptr;
    logic [31:0]           held_dw;
    logic [TAG_W-1:0]      cur_tag;

    function automatic logic [31:0] swap_dw(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    assign beat = !trn_rsrc_rdy_n && !trn_rdst_rdy_n;

    assign hdr_ok = !trn_rsof_n &&
                    (trn_rd[FMT_TYPE_LSB +: $bits(CPL_D_FMT_TYPE)] == CPL_D_FMT_TYPE) &&
                    (trn_rd[STATUS_LSB +: $bits(CPL_SC)] == CPL_SC);

    assign take_tag  = (state == ST_TAG) && beat;
    assign take_data = (state == ST_DATA) && beat;
    assign write_qw  = take_data && (qw_left != '0);  // guard against overlong tlps

    assign lookup_tag = trn_rd[TAG_LSB +: TAG_W];    // valid on the tag beat
    assign cpl_tag    = cur_tag;
    assign cpl_qword  = wr_en;

    //////////////////////////////////////////////////
    // tlp framing
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state   <= ST_HDR;
            wr_en   <= 1'b0;
            qw_left <= '0;
        end
        else begin
            wr_en <= write_qw;
            case (state)
                ST_HDR: begin
                    // non-sof beats are dropped here, which skips rejected tlps
                    if (beat && hdr_ok) begin
                        qw_left <= trn_rd[LEN_LSB + 1 +: CHUNK_W];  // dwords / 2
                        state   <= ST_TAG;
                    end
                end
                ST_TAG: begin
                    if (beat) begin
                        state <= trn_reof_n ? ST_DATA : ST_HDR;
                    end
                end
                ST_DATA: begin
                    if (write_qw) begin
                        qw_left <= qw_left - 1'b1;
                    end
                    if (beat && !trn_reof_n) begin
                        state <= ST_HDR;
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (take_tag) begin
            cur_tag <= lookup_tag;
            wr_ptr  <= lookup_addr[BUF_ADDR_W-1:0];  // base plus qwords already in
            held_dw <= trn_rd[31:0];                 // dword 3 is the first payload dword
        end
        else if (take_data) begin
            held_dw <= trn_rd[31:0];
        end
        if (write_qw) begin
            wr_addr <= wr_ptr;
            // held dword is lower numbered, goes to the upper half
            wr_data <= {swap_dw(held_dw), swap_dw(trn_rd[63:32])};
            wr_ptr  <= wr_ptr + 1'b1;
        end
    end

endmodule

// ==== src/read_request_scheduler.sv ====
// page must be qword aligned and non-empty; host holds page_valid until page_done
`timescale 1ns/1ps

module read_request_scheduler
    import tx_dma_pkg::*;
(
    input  logic                   trn_clk,
    input  logic                   reset,

    input  logic                   page_valid,
    input  logic [HOST_ADDR_W-1:0] page_addr,
    input  logic [PAGE_QW_W-1:0]   page_qwords,
    output logic                   page_done,

    input  logic [2:0]             cfg_max_rd_req_size,
    input  logic [PTR_W-1:0]       commited_rd_addr,

    output logic                   read_chunk,
    output logic [HOST_ADDR_W-1:0] read_addr,
    output logic [CHUNK_W-1:0]     read_qwords,
    output logic [TAG_W-1:0]       read_tag,
    input  logic                   read_chunk_ack,

    input  logic [2:0]             outstanding,
    output logic                   req_fire,
    output logic [PTR_W-1:0]       req_base
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SIZE0,
        S_SIZE1,
        S_WAIT,
        S_REQ,
        S_DONE
    } state_t;

    state_t               state;
    logic [2:0]           cfg_q0;
    logic [2:0]           cfg_q1;
    logic [CHUNK_W-1:0]   chunk_sz;
    logic [PAGE_QW_W-1:0] qw_left;
    logic [PTR_W-1:0]     used;
    logic [PTR_W:0]       fill_next;
    logic                 space_ok;
    logic                 last_req;

    assign req_fire  = read_chunk && read_chunk_ack;
    assign used      = req_base - commited_rd_addr;   // wrap bit keeps this exact
    assign fill_next = {1'b0, used} + read_qwords;
    assign last_req  = (qw_left == PAGE_QW_W'(read_qwords));

    //////////////////////////////////////////////////
    // config sync and space check
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        cfg_q0   <= cfg_max_rd_req_size;
        cfg_q1   <= cfg_q0;
        chunk_sz <= chunk_qwords[cfg_q1[2] ? 2'd3 : cfg_q1[1:0]];  // 4 and up act as 1k
        space_ok <= (fill_next <= BUF_QWORDS);
    end

    //////////////////////////////////////////////////
    // request fsm
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state      <= S_IDLE;
            read_chunk <= 1'b0;
            page_done  <= 1'b0;
            req_base   <= '0;
            read_tag   <= '0;
        end
        else begin
            page_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (page_valid) begin
                        state <= S_SIZE0;
                    end
                end
                S_SIZE0: state <= S_SIZE1;   // size is picked here
                S_SIZE1: state <= S_WAIT;    // space_ok catches up with new size
                S_WAIT: begin
                    if (space_ok && (outstanding < NUM_TAGS)) begin
                        read_chunk <= 1'b1;
                        state      <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (read_chunk_ack) begin
                        read_chunk <= 1'b0;
                        req_base   <= req_base + read_qwords;
                        read_tag   <= read_tag + 1'b1;  // tag is request count mod 4
                        if (last_req) begin
                            page_done <= 1'b1;
                            state     <= S_DONE;
                        end
                        else begin
                            state <= S_SIZE0;
                        end
                    end
                end
                S_DONE: begin
                    if (!page_valid) begin   // wait for host to drop the page
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // page address and length tracking
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if ((state == S_IDLE) && page_valid) begin
            read_addr <= page_addr;
            qw_left   <= page_qwords;
        end
        else if (req_fire) begin
            read_addr <= read_addr + {read_qwords, 3'b000};  // 8 bytes per qword
            qw_left   <= qw_left - read_qwords;
        end
        if (state == S_SIZE0) begin
            read_qwords <= (qw_left < chunk_sz) ? qw_left[CHUNK_W-1:0] : chunk_sz;
        end
    end

endmodule

// ==== src/commit_tracker.sv ====
// completions of one tag arrive in address order; tags are issued and retired in order
`timescale 1ns/1ps

module commit_tracker
    import tx_dma_pkg::*;
(
    input  logic               trn_clk,
    input  logic               reset,

    input  logic               req_fire,
    input  logic [TAG_W-1:0]   req_tag,
    input  logic [PTR_W-1:0]   req_base,
    input  logic [CHUNK_W-1:0] req_qwords,

    input  logic [TAG_W-1:0]   lookup_tag,
    output logic [PTR_W-1:0]   lookup_addr,

    input  logic [TAG_W-1:0]   cpl_tag,
    input  logic               cpl_qword,

    output logic [2:0]         outstanding,
    output logic [PTR_W-1:0]   commited_wr_addr
);

    logic [PTR_W-1:0]    ent_base [NUM_TAGS];
    logic [CHUNK_W-1:0]  ent_req  [NUM_TAGS];
    logic [CHUNK_W-1:0]  ent_rcv  [NUM_TAGS];
    logic [NUM_TAGS-1:0] ent_busy;
    logic [TAG_W-1:0]    oldest;
    logic                commit_now;

    assign lookup_addr = ent_base[lookup_tag] + PTR_W'(ent_rcv[lookup_tag]);
    assign commit_now  = ent_busy[oldest] && (ent_rcv[oldest] == ent_req[oldest]);

    // per-tag entries
    always_ff @(posedge trn_clk) begin
        if (req_fire) begin
            ent_base[req_tag] <= req_base;
            ent_req[req_tag]  <= req_qwords;
            ent_rcv[req_tag]  <= '0;
        end
        if (cpl_qword) begin
            ent_rcv[cpl_tag] <= ent_rcv[cpl_tag] + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // in-order commit
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            ent_busy         <= '0;
            oldest           <= '0;
            outstanding      <= '0;
            commited_wr_addr <= '0;
        end
        else begin
            if (req_fire) begin
                ent_busy[req_tag] <= 1'b1;
            end
            if (commit_now) begin
                ent_busy[oldest] <= 1'b0;   // tag free for reuse
                oldest           <= oldest + 1'b1;
                commited_wr_addr <= ent_base[oldest] + PTR_W'(ent_req[oldest]);
            end
            case ({req_fire, commit_now})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

endmodule

// ==== src/tx_buffer_fill.sv ====
// one page at a time; buffer reads and commited_rd_addr are owned by the consumer side
`timescale 1ns/1ps

module tx_buffer_fill
    import tx_dma_pkg::*;
(
    input  logic                   trn_clk,
    input  logic                   reset,

    // host page
    input  logic                   page_valid,
    input  logic [HOST_ADDR_W-1:0] page_addr,
    input  logic [PAGE_QW_W-1:0]   page_qwords,
    output logic                   page_done,
    input  logic [2:0]             cfg_max_rd_req_size,

    // read requests
    output logic                   read_chunk,
    output logic [HOST_ADDR_W-1:0] read_addr,
    output logic [CHUNK_W-1:0]     read_qwords,
    output logic [TAG_W-1:0]       read_tag,
    input  logic                   read_chunk_ack,

    // completions in
    input  logic [QWORD_W-1:0]     trn_rd,
    input  logic                   trn_rsof_n,
    input  logic                   trn_reof_n,
    input  logic                   trn_rsrc_rdy_n,
    input  logic                   trn_rdst_rdy_n,

    // buffer side
    output logic                   wr_en,
    output logic [BUF_ADDR_W-1:0]  wr_addr,
    output logic [QWORD_W-1:0]     wr_data,
    input  logic [PTR_W-1:0]       commited_rd_addr,
    output logic [PTR_W-1:0]       commited_wr_addr
);

    logic               req_fire;
    logic [PTR_W-1:0]   req_base;
    logic [2:0]         outstanding;
    logic [TAG_W-1:0]   lookup_tag;
    logic [PTR_W-1:0]   lookup_addr;
    logic [TAG_W-1:0]   cpl_tag;
    logic               cpl_qword;

    read_request_scheduler sched0 (
        .trn_clk             (trn_clk),
        .reset               (reset),
        .page_valid          (page_valid),
        .page_addr           (page_addr),
        .page_qwords         (page_qwords),
        .page_done           (page_done),
        .cfg_max_rd_req_size (cfg_max_rd_req_size),
        .commited_rd_addr    (commited_rd_addr),
        .read_chunk          (read_chunk),
        .read_addr           (read_addr),
        .read_qwords         (read_qwords),
        .read_tag            (read_tag),
        .read_chunk_ack      (read_chunk_ack),
        .outstanding         (outstanding),
        .req_fire            (req_fire),
        .req_base            (req_base)
    );

    completion_parser parser0 (
        .trn_clk        (trn_clk),
        .reset          (reset),
        .trn_rd         (trn_rd),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rdst_rdy_n (trn_rdst_rdy_n),
        .lookup_tag     (lookup_tag),
        .lookup_addr    (lookup_addr),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .cpl_tag        (cpl_tag),
        .cpl_qword      (cpl_qword)
    );

    commit_tracker tracker0 (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .req_fire         (req_fire),
        .req_tag          (read_tag),       // held stable until the ack
        .req_base         (req_base),
        .req_qwords       (read_qwords),
        .lookup_tag       (lookup_tag),
        .lookup_addr      (lookup_addr),
        .cpl_tag          (cpl_tag),
        .cpl_qword        (cpl_qword),
        .outstanding      (outstanding),
        .commited_wr_addr (commited_wr_addr)
    );

endmodule

// ==== verification/tb_tx_buffer_fill.sv ====
// runs one page at a time, answers each request in order unless a test says otherwise; no trn stalls
`timescale 1ns/1ps

module tb_tx_buffer_fill
    import tx_dma_pkg::*;
    import tlp_pkg::*;
();

    localparam int TIMEOUT = 2000;            // cycles allowed per wait

    logic                   trn_clk = 1'b0;
    logic                   reset;
    logic                   page_valid;
    logic [HOST_ADDR_W-1:0] page_addr;
    logic [PAGE_QW_W-1:0]   page_qwords;
    logic                   page_done;
    logic [2:0]             cfg_max_rd_req_size;
    logic                   read_chunk;
    logic [HOST_ADDR_W-1:0] read_addr;
    logic [CHUNK_W-1:0]     read_qwords;
    logic [TAG_W-1:0]       read_tag;
    logic                   read_chunk_ack;
    logic [QWORD_W-1:0]     trn_rd;
    logic                   trn_rsof_n;
    logic                   trn_reof_n;
    logic                   trn_rsrc_rdy_n;
    logic                   trn_rdst_rdy_n;
    logic                   wr_en;
    logic [BUF_ADDR_W-1:0]  wr_addr;
    logic [QWORD_W-1:0]     wr_data;
    logic [PTR_W-1:0]       commited_rd_addr;
    logic [PTR_W-1:0]       commited_wr_addr;

    logic [QWORD_W-1:0]     shadow  [BUF_QWORDS];  // every buffer write lands here
    logic [QWORD_W-1:0]     exp_mem [BUF_QWORDS];
    logic                   exp_set [BUF_QWORDS];
    logic [31:0]            lfsr_state = 32'h9d6a;
    logic [PTR_W-1:0]       wptr = '0;             // model of the next buffer base
    logic [HOST_ADDR_W-1:0] host_addr;
    logic [TAG_W-1:0]       model_tag = '0;
    logic [TAG_W-1:0]       last_tag;
    logic [PTR_W-1:0]       last_base;
    int                     last_qw;
    int                     done_count = 0;
    int                     done_start;
    int                     wr_count = 0;
    int                     errors = 0;
    int                     test_err0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    string                  cur_test;

    tx_buffer_fill dut0 (.*);

    always #4 trn_clk = ~trn_clk;

    always @(posedge trn_clk) begin
        if (wr_en) begin
            shadow[wr_addr] <= wr_data;
            wr_count        <= wr_count + 1;
        end
        if (page_done) begin
            done_count <= done_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    task automatic rand_dword(output logic [31:0] d);
        for (int b = 0; b < 32; b++) begin
            d[b]       = lfsr_state[0];       // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [31:0] reverse_bytes(input logic [31:0] dw);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = dw[8*(3-i) +: 8];
        end
        return r;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("Mismatch in %s, %s: expected %0h, actual %0h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors != test_err0) begin
            tests_failed++;
        end
        $display("%-20s %s", cur_test, (errors == test_err0) ? "ok" : "fail");
    endtask

    task automatic start_page(input logic [HOST_ADDR_W-1:0] addr, input int qw,
                              input logic [2:0] cfg);
        cfg_max_rd_req_size <= cfg;
        repeat (4) @(posedge trn_clk);        // config sync settles
        page_addr   <= addr;
        page_qwords <= qw;
        page_valid  <= 1'b1;
        host_addr  = addr;
        done_start = done_count;
    endtask

    // host side waits for a request, checks it against the model and acks it
    task automatic take_request(input int exp_qw);
        int n;
        n = 0;
        @(posedge trn_clk);
        while (!read_chunk && n < TIMEOUT) begin
            @(posedge trn_clk);
            n++;
        end
        if (!read_chunk) begin
            $display("%s: no read request within %0d cycles", cur_test, TIMEOUT);
            errors++;
        end
        else begin
            if (read_qwords !== exp_qw) report_mismatch("read_qwords", exp_qw, read_qwords);
            if (read_addr !== host_addr) report_mismatch("read_addr", host_addr, read_addr);
            if (read_tag !== model_tag) report_mismatch("read_tag", model_tag, read_tag);
            last_tag  = read_tag;
            last_base = wptr;
            last_qw   = read_qwords;
            read_chunk_ack <= 1'b1;
            @(posedge trn_clk);
            read_chunk_ack <= 1'b0;
            host_addr = host_addr + 64'(exp_qw * 8);
            wptr      = wptr + PTR_W'(exp_qw);
            model_tag = model_tag + 1'b1;
        end
    endtask

    task automatic finish_page();
        int n;
        n = 0;
        while (done_count == done_start && n < TIMEOUT) begin
            @(posedge trn_clk);
            n++;
        end
        if (done_count == done_start) begin
            $display("%s: page_done never pulsed", cur_test);
            errors++;
        end
        page_valid <= 1'b0;
    endtask

    task automatic wait_commit(input logic [PTR_W-1:0] target);
        int n;
        n = 0;
        while (commited_wr_addr !== target && n < TIMEOUT) begin
            @(posedge trn_clk);
            n++;
        end
        if (commited_wr_addr !== target) report_mismatch("commited_wr_addr", target,
                                                         commited_wr_addr);
    endtask

    // completer sends a header beat and a tag beat, then one beat per qword
    task automatic send_completion(input logic [TAG_W-1:0] tag, input logic [PTR_W-1:0] base,
                                   input int qw, input logic [2:0] status);
        logic [31:0]        dw [0:255];
        logic [QWORD_W-1:0] beat;
        for (int i = 0; i < 2 * qw; i++) begin
            rand_dword(dw[i]);
        end
        if (status == CPL_SC) begin
            for (int i = 0; i < qw; i++) begin
                exp_mem[BUF_ADDR_W'(base + PTR_W'(i))] = {reverse_bytes(dw[2*i]),
                                                          reverse_bytes(dw[2*i+1])};
                exp_set[BUF_ADDR_W'(base + PTR_W'(i))] = 1'b1;
            end
        end
        for (int k = 0; k < qw + 2; k++) begin
            beat = '0;
            if (k == 0) begin
                beat[FMT_TYPE_LSB +: 7] = CPL_D_FMT_TYPE;
                beat[LEN_LSB +: 10]     = 10'(2 * qw);
                beat[STATUS_LSB +: 3]   = status;
            end
            else if (k == 1) begin
                beat[TAG_LSB +: 8] = 8'(tag);
                beat[31:0]         = dw[0];
            end
            else begin
                beat[63:32] = dw[2*k-3];
                if (2 * k - 2 < 2 * qw) beat[31:0] = dw[2*k-2];  // last beat half empty
            end
            @(posedge trn_clk);
            trn_rd         <= beat;
            trn_rsof_n     <= (k != 0);
            trn_reof_n     <= (k != qw + 1);
            trn_rsrc_rdy_n <= 1'b0;
        end
        @(posedge trn_clk);
        trn_rsrc_rdy_n <= 1'b1;
        trn_rsof_n     <= 1'b1;
        trn_reof_n     <= 1'b1;
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic reset_test();
        begin_test("reset_values");
        if (read_chunk !== 1'b0) report_mismatch("read_chunk", 0, read_chunk);
        if (page_done !== 1'b0) report_mismatch("page_done", 0, page_done);
        if (wr_en !== 1'b0) report_mismatch("wr_en", 0, wr_en);
        if (commited_wr_addr !== '0) report_mismatch("commited_wr_addr", 0, commited_wr_addr);
        end_test();
    endtask

    task automatic chunk_sizing_test();
        int left;
        int sz;
        begin_test("chunk_sizing");
        start_page(64'h0000_0001_2345_6000, 100, 3'd0);
        left = 100;
        while (left > 0) begin
            sz = (left < 16) ? left : 16;     // 128 byte requests
            take_request(sz);
            send_completion(last_tag, last_base, last_qw, CPL_SC);
            left -= sz;
        end
        finish_page();
        repeat (4) @(posedge trn_clk);
        if (done_count != done_start + 1) report_mismatch("page_done pulses", done_start + 1,
                                                          done_count);
        wait_commit(wptr);
        end_test();
    endtask

    task automatic data_placement_test();
        begin_test("data_placement");
        for (int a = 0; a < BUF_QWORDS; a++) begin
            if (exp_set[a] && shadow[a] !== exp_mem[a]) report_mismatch($sformatf("qword %0d", a),
                                                                        exp_mem[a], shadow[a]);
        end
        end_test();
    endtask

    task automatic ordered_commit_test();
        logic [TAG_W-1:0] tag_a;
        logic [PTR_W-1:0] base_a;
        logic [PTR_W-1:0] commit_before;
        logic             moved;
        begin_test("ordered_commit");
        start_page(64'h0000_0000_0008_0000, 32, 3'd0);
        take_request(16);
        tag_a  = last_tag;
        base_a = last_base;
        take_request(16);
        finish_page();
        commit_before = commited_wr_addr;
        send_completion(last_tag, last_base, 16, CPL_SC);  // younger request first
        moved = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(posedge trn_clk);
            if (commited_wr_addr !== commit_before) moved = 1'b1;
        end
        if (moved) begin
            $display("%s: commit pointer moved before the older request completed", cur_test);
            errors++;
        end
        send_completion(tag_a, base_a, 16, CPL_SC);
        wait_commit(last_base + PTR_W'(16));
        end_test();
    endtask

    task automatic space_backpressure_test();
        int   left;
        logic issued;
        begin_test("space_backpressure");
        start_page(64'h0000_0000_0010_0000, 512, 3'd3);
        left = 512;
        while (left > 0 && int'(PTR_W'(wptr - commited_rd_addr)) + 128 <= BUF_QWORDS) begin
            take_request(128);
            send_completion(last_tag, last_base, last_qw, CPL_SC);
            left -= 128;
        end
        wait_commit(wptr);
        issued = 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(posedge trn_clk);
            if (read_chunk) issued = 1'b1;
        end
        if (issued) begin
            $display("%s: read request issued without buffer space", cur_test);
            errors++;
        end
        commited_rd_addr <= wptr;             // consumer drains the buffer
        while (left > 0) begin
            take_request(128);
            send_completion(last_tag, last_base, last_qw, CPL_SC);
            left -= 128;
        end
        finish_page();
        wait_commit(wptr);
        end_test();
    endtask

    task automatic bad_status_test();
        int               writes_before;
        logic [PTR_W-1:0] commit_before;
        begin_test("bad_status");
        writes_before = wr_count;
        commit_before = commited_wr_addr;
        send_completion(model_tag, wptr, 4, 3'b001);  // unsupported request
        repeat (10) @(posedge trn_clk);
        if (wr_count != writes_before) report_mismatch("write count", writes_before, wr_count);
        if (commited_wr_addr !== commit_before) report_mismatch("commited_wr_addr",
                                                                commit_before, commited_wr_addr);
        end_test();
    endtask

    initial begin
        reset               = 1'b1;
        page_valid          = 1'b0;
        page_addr           = '0;
        page_qwords         = '0;
        cfg_max_rd_req_size = 3'd0;
        read_chunk_ack      = 1'b0;
        trn_rd              = '0;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rdst_rdy_n      = 1'b0;           // buffer side always ready
        commited_rd_addr    = '0;
        for (int a = 0; a < BUF_QWORDS; a++) begin
            exp_set[a] = 1'b0;
        end
        repeat (8) @(posedge trn_clk);
        reset <= 1'b0;
        @(posedge trn_clk);
        reset_test();
        chunk_sizing_test();
        data_placement_test();
        ordered_commit_test();
        space_backpressure_test();
        bad_status_test();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end
        else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/tx_dma_pkg.sv
src/tlp_pkg.sv
src/completion_parser.sv
src/read_request_scheduler.sv
src/commit_tracker.sv
src/tx_buffer_fill.sv
verification/tb_tx_buffer_fill.sv
